// ==== logic/system_pkg.sv ====
// Shared data types, enums, address map and memory geometry
// for the system memory side of the cluster

package system_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;

  // Decoded destination of a host request
  typedef enum logic [1:0] {
    TgtL2,
    TgtBootrom,
    TgtCtrl,
    TgtNone
  } target_e;

  // Byte offset bits inside one data word
  localparam int unsigned ByteOffsetWidth = $clog2($bits(strb_t));

  // Word index inside a 64 KiB peripheral window
  localparam int unsigned WinWordIdxWidth = 16 - ByteOffsetWidth;

  // Control register word offsets
  typedef enum logic [WinWordIdxWidth-1:0] {
    RegEoc      = 0,
    RegWakeUp   = 1,
    RegNumCores = 2
  } ctrl_reg_e;

  // L2 bank geometry, word interleaved across banks
  localparam int unsigned NumL2Banks      = 4;
  localparam int unsigned L2BankNumWords  = 256;
  localparam int unsigned L2BankSelLsb    = ByteOffsetWidth;
  localparam int unsigned L2BankIdxWidth  = $clog2(NumL2Banks);
  localparam int unsigned L2BankAddrWidth = $clog2(L2BankNumWords);
  localparam int unsigned L2Size          = NumL2Banks * L2BankNumWords * $bits(strb_t);

  // Address map
  localparam addr_t L2BaseAddr      = 32'h8000_0000;
  localparam addr_t BootromBaseAddr = 32'hA000_0000;
  localparam addr_t BootromEndAddr  = 32'hA001_0000;
  localparam addr_t CtrlBaseAddr    = 32'h4000_0000;
  localparam addr_t CtrlEndAddr     = 32'h4001_0000;

  // Boot ROM content
  localparam int unsigned BootromNumWords  = 64;
  localparam logic [15:0] BootromSignature = 16'hB007;

  localparam int unsigned NumCores = 8;

  // Requests in flight, kept a power of two so queue pointers wrap freely
  localparam int unsigned OrderDepth    = 4;
  localparam int unsigned OrderPtrWidth = $clog2(OrderDepth);

endpackage : system_pkg

// ==== logic/mem_req_if.sv ====
// Word request and response channel, valid/ready on both directions

interface mem_req_if ();

  // Request group
  logic                req_valid;
  logic                req_ready;
  system_pkg::addr_t   req_addr;
  logic                req_write;
  system_pkg::data_t   req_wdata;
  system_pkg::strb_t   req_strb;

  // Response group
  logic                rsp_valid;
  logic                rsp_ready;
  system_pkg::data_t   rsp_rdata;
  logic                rsp_error;

  modport initiator (
    output req_valid, req_addr, req_write, req_wdata, req_strb, rsp_ready,
    input  req_ready, rsp_valid, rsp_rdata, rsp_error
  );

  modport target (
    input  req_valid, req_addr, req_write, req_wdata, req_strb, rsp_ready,
    output req_ready, rsp_valid, rsp_rdata, rsp_error
  );

endinterface : mem_req_if

// ==== logic/soc_demux.sv ====
// Address decoder with an order queue that returns responses
// in request order, plus the error responder for unmapped addresses

module soc_demux (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              req_valid_i,
  input  logic              req_write_i,
  input  logic              rsp_ready_i,
  input  system_pkg::addr_t req_addr_i,
  input  system_pkg::data_t req_wdata_i,
  input  system_pkg::strb_t req_strb_i,
  output logic              req_ready_o,
  output logic              rsp_valid_o,
  output logic              rsp_error_o,
  output system_pkg::data_t rsp_rdata_o,
  mem_req_if.initiator      l2_if,
  mem_req_if.initiator      rom_if,
  mem_req_if.initiator      ctrl_if
);

  system_pkg::target_e tgt;
  system_pkg::target_e head;
  system_pkg::target_e order_q [system_pkg::OrderDepth];

  logic [system_pkg::OrderPtrWidth-1:0] wr_ptr, rd_ptr;
  logic [system_pkg::OrderPtrWidth:0]   count;
  logic q_full, q_empty, room;
  logic tgt_ready;
  logic push, pop;

  // Address map lookup
  always_comb begin
    tgt = system_pkg::TgtNone;
    if (req_addr_i >= system_pkg::L2BaseAddr &&
        req_addr_i < system_pkg::L2BaseAddr + system_pkg::addr_t'(system_pkg::L2Size)) begin
      tgt = system_pkg::TgtL2;
    end else if (req_addr_i >= system_pkg::BootromBaseAddr &&
                 req_addr_i < system_pkg::BootromEndAddr) begin
      tgt = system_pkg::TgtBootrom;
    end else if (req_addr_i >= system_pkg::CtrlBaseAddr &&
                 req_addr_i < system_pkg::CtrlEndAddr) begin
      tgt = system_pkg::TgtCtrl;
    end
  end

  assign q_full  = (count == system_pkg::OrderDepth);
  assign q_empty = (count == '0);
  assign room    = !q_full;
  assign head    = order_q[rd_ptr];

  // Request side, payload goes to every target and only valid is steered
  assign l2_if.req_valid   = req_valid_i && room && (tgt == system_pkg::TgtL2);
  assign rom_if.req_valid  = req_valid_i && room && (tgt == system_pkg::TgtBootrom);
  assign ctrl_if.req_valid = req_valid_i && room && (tgt == system_pkg::TgtCtrl);

  assign l2_if.req_addr    = req_addr_i;
  assign l2_if.req_write   = req_write_i;
  assign l2_if.req_wdata   = req_wdata_i;
  assign l2_if.req_strb    = req_strb_i;
  assign rom_if.req_addr   = req_addr_i;
  assign rom_if.req_write  = req_write_i;
  assign rom_if.req_wdata  = req_wdata_i;
  assign rom_if.req_strb   = req_strb_i;
  assign ctrl_if.req_addr  = req_addr_i;
  assign ctrl_if.req_write = req_write_i;
  assign ctrl_if.req_wdata = req_wdata_i;
  assign ctrl_if.req_strb  = req_strb_i;

  always_comb begin
    case (tgt)
      system_pkg::TgtL2:      tgt_ready = l2_if.req_ready;
      system_pkg::TgtBootrom: tgt_ready = rom_if.req_ready;
      system_pkg::TgtCtrl:    tgt_ready = ctrl_if.req_ready;
      default:                tgt_ready = 1'b1;
    endcase
  end

  assign req_ready_o = tgt_ready && room;
  assign push        = req_valid_i && req_ready_o;
  assign pop         = rsp_valid_o && rsp_ready_i;

  // Response side serves only the target at the head of the queue
  always_comb begin
    rsp_valid_o       = 1'b0;
    rsp_error_o       = 1'b0;
    rsp_rdata_o       = '0;
    l2_if.rsp_ready   = 1'b0;
    rom_if.rsp_ready  = 1'b0;
    ctrl_if.rsp_ready = 1'b0;
    if (!q_empty) begin
      case (head)
        system_pkg::TgtL2: begin
          rsp_valid_o     = l2_if.rsp_valid;
          rsp_error_o     = l2_if.rsp_error;
          rsp_rdata_o     = l2_if.rsp_rdata;
          l2_if.rsp_ready = rsp_ready_i;
        end
        system_pkg::TgtBootrom: begin
          rsp_valid_o      = rom_if.rsp_valid;
          rsp_error_o      = rom_if.rsp_error;
          rsp_rdata_o      = rom_if.rsp_rdata;
          rom_if.rsp_ready = rsp_ready_i;
        end
        system_pkg::TgtCtrl: begin
          rsp_valid_o       = ctrl_if.rsp_valid;
          rsp_error_o       = ctrl_if.rsp_error;
          rsp_rdata_o       = ctrl_if.rsp_rdata;
          ctrl_if.rsp_ready = rsp_ready_i;
        end
        default: begin
          // Unmapped address answers straight away
          rsp_valid_o = 1'b1;
          rsp_error_o = 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      order_q[wr_ptr] <= tgt;
    end
  end

  // Occupancy never passes the depth and matches the pointer distance
  a_no_push_when_full : assert property (
    @(posedge clk_i) disable iff (rst_i)
    count <= system_pkg::OrderDepth &&
    count[system_pkg::OrderPtrWidth-1:0] == wr_ptr - rd_ptr);

  a_rsp_stable : assert property (
    @(posedge clk_i) disable iff (rst_i)
    rsp_valid_o && !rsp_ready_i |=>
      rsp_valid_o && $stable(rsp_rdata_o) && $stable(rsp_error_o));

endmodule : soc_demux

// ==== logic/l2_mem.sv ====
// Word-interleaved L2 SRAM built from several banks
// with a single response register

module l2_mem (
  input  logic      clk_i,
  input  logic      rst_i,
  mem_req_if.target bus
);

  logic accept;
  logic rsp_valid_q;
  logic write_q;

  logic [system_pkg::L2BankIdxWidth-1:0]  bank_sel;
  logic [system_pkg::L2BankIdxWidth-1:0]  bank_sel_q;
  logic [system_pkg::L2BankAddrWidth-1:0] word_addr;
  system_pkg::addr_t                      addr_scrambled;
  system_pkg::data_t                      bank_rdata [system_pkg::NumL2Banks];

  // Take a new request when the response slot is free or draining
  assign bus.req_ready = !rsp_valid_q || bus.rsp_ready;
  assign accept        = bus.req_valid && bus.req_ready;

  assign bank_sel = bus.req_addr[system_pkg::L2BankSelLsb +: system_pkg::L2BankIdxWidth];

  // Bank select bits are cut out, the rest closes up above the byte offset
  assign addr_scrambled = {
    {system_pkg::L2BankIdxWidth{1'b0}},
    bus.req_addr[$bits(system_pkg::addr_t)-1:
                 system_pkg::L2BankSelLsb + system_pkg::L2BankIdxWidth],
    bus.req_addr[system_pkg::L2BankSelLsb-1:0]
  };
  assign word_addr = addr_scrambled[system_pkg::ByteOffsetWidth +: system_pkg::L2BankAddrWidth];

  for (genvar b = 0; b < system_pkg::NumL2Banks; b++) begin : gen_bank
    system_pkg::data_t mem_q [system_pkg::L2BankNumWords];

    always_ff @(posedge clk_i) begin
      if (accept && bank_sel == b) begin
        if (bus.req_write) begin
          for (int i = 0; i < $bits(system_pkg::strb_t); i++) begin
            if (bus.req_strb[i]) begin
              mem_q[word_addr][8*i +: 8] <= bus.req_wdata[8*i +: 8];
            end
          end
        end else begin
          bank_rdata[b] <= mem_q[word_addr];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (bus.rsp_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Which bank answers and whether the access was a write
  always_ff @(posedge clk_i) begin
    if (accept) begin
      bank_sel_q <= bank_sel;
      write_q    <= bus.req_write;
    end
  end

  assign bus.rsp_valid = rsp_valid_q;
  assign bus.rsp_rdata = write_q ? '0 : bank_rdata[bank_sel_q];
  assign bus.rsp_error = 1'b0;

  a_addr_in_range : assert property (
    @(posedge clk_i) disable iff (rst_i)
    accept |-> (bus.req_addr - system_pkg::L2BaseAddr) < system_pkg::L2Size);

endmodule : l2_mem

// ==== logic/bootrom.sv ====
// Read-only boot memory, each word holds a signature and its own index

module bootrom (
  input  logic      clk_i,
  input  logic      rst_i,
  mem_req_if.target bus
);

  logic accept;
  logic rsp_valid_q;
  logic rsp_error_q;

  logic [system_pkg::WinWordIdxWidth-1:0] word_idx;
  system_pkg::data_t                      rom_word;
  system_pkg::data_t                      rsp_rdata_q;

  assign bus.req_ready = !rsp_valid_q || bus.rsp_ready;
  assign accept        = bus.req_valid && bus.req_ready;

  assign word_idx = bus.req_addr[system_pkg::ByteOffsetWidth +: system_pkg::WinWordIdxWidth];

  // Content rule, zero past the populated words
  always_comb begin
    rom_word = '0;
    if (word_idx < system_pkg::BootromNumWords) begin
      rom_word = {system_pkg::BootromSignature, 16'(word_idx)};
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;
    end else if (bus.rsp_ready) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // Writes leave the content untouched and are flagged
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_error_q <= bus.req_write;
      rsp_rdata_q <= bus.req_write ? '0 : rom_word;
    end
  end

  assign bus.rsp_valid = rsp_valid_q;
  assign bus.rsp_rdata = rsp_rdata_q;
  assign bus.rsp_error = rsp_error_q;

endmodule : bootrom

// ==== logic/ctrl_registers.sv ====
// Control registers: end of computation, core wake-up pulse
// and the read-only core count

module ctrl_registers (
  input  logic                            clk_i,
  input  logic                            rst_i,
  mem_req_if.target                       bus,
  output logic                            eoc_valid_o,
  output logic [system_pkg::NumCores-1:0] wake_up_o
);

  logic accept;
  logic wake_write;
  logic rsp_valid_q;
  logic rsp_error_q;
  logic rd_error;

  logic [system_pkg::WinWordIdxWidth-1:0] offset;
  logic [system_pkg::NumCores-1:0]        wake_up_q;
  system_pkg::data_t                      eoc_q;
  system_pkg::data_t                      rd_data;
  system_pkg::data_t                      rsp_rdata_q;

  assign offset     = bus.req_addr[system_pkg::ByteOffsetWidth +: system_pkg::WinWordIdxWidth];
  assign wake_write = bus.req_write && (offset == system_pkg::RegWakeUp);

  // A wake-up write right behind another pulse waits one cycle,
  // so the cores always see separate pulses
  assign bus.req_ready = (!rsp_valid_q || bus.rsp_ready) && !(wake_write && wake_up_q != '0);
  assign accept        = bus.req_valid && bus.req_ready;

  // Read data and decode error for the addressed word
  always_comb begin
    rd_data  = '0;
    rd_error = 1'b0;
    case (offset)
      system_pkg::RegEoc:      rd_data = bus.req_write ? '0 : eoc_q;
      system_pkg::RegWakeUp:   rd_data = '0;
      system_pkg::RegNumCores: rd_data = bus.req_write ? '0 : system_pkg::data_t'(system_pkg::NumCores);
      default:                 rd_error = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
      eoc_q       <= '0;
      wake_up_q   <= '0;
    end else begin
      wake_up_q <= '0;
      if (accept) begin
        rsp_valid_q <= 1'b1;
        if (bus.req_write && offset == system_pkg::RegEoc) begin
          for (int i = 0; i < $bits(system_pkg::strb_t); i++) begin
            if (bus.req_strb[i]) begin
              eoc_q[8*i +: 8] <= bus.req_wdata[8*i +: 8];
            end
          end
        end
        if (wake_write) begin
          wake_up_q <= bus.req_wdata[system_pkg::NumCores-1:0];
        end
      end else if (bus.rsp_ready) begin
        rsp_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_rdata_q <= rd_data;
      rsp_error_q <= rd_error;
    end
  end

  assign bus.rsp_valid = rsp_valid_q;
  assign bus.rsp_rdata = rsp_rdata_q;
  assign bus.rsp_error = rsp_error_q;
  assign eoc_valid_o   = eoc_q[0];
  assign wake_up_o     = wake_up_q;

  a_wake_up_single_cycle : assert property (
    @(posedge clk_i) disable iff (rst_i) (wake_up_o != '0) |=> (wake_up_o == '0));

endmodule : ctrl_registers

// ==== logic/mempool_system.sv ====
// System top level: host port, address decoder, L2 SRAM,
// boot ROM and control registers

module mempool_system (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            req_valid_i,
  input  logic                            req_write_i,
  input  logic                            rsp_ready_i,
  input  system_pkg::addr_t               req_addr_i,
  input  system_pkg::data_t               req_wdata_i,
  input  system_pkg::strb_t               req_strb_i,
  output logic                            req_ready_o,
  output logic                            rsp_valid_o,
  output logic                            rsp_error_o,
  output logic                            eoc_valid_o,
  output system_pkg::data_t               rsp_rdata_o,
  output logic [system_pkg::NumCores-1:0] wake_up_o
);

  mem_req_if l2_if ();
  mem_req_if rom_if ();
  mem_req_if ctrl_if ();

  soc_demux i_soc_demux (
    .clk_i      (clk_i      ),
    .rst_i      (rst_i      ),
    .req_valid_i(req_valid_i),
    .req_write_i(req_write_i),
    .rsp_ready_i(rsp_ready_i),
    .req_addr_i (req_addr_i ),
    .req_wdata_i(req_wdata_i),
    .req_strb_i (req_strb_i ),
    .req_ready_o(req_ready_o),
    .rsp_valid_o(rsp_valid_o),
    .rsp_error_o(rsp_error_o),
    .rsp_rdata_o(rsp_rdata_o),
    .l2_if      (l2_if      ),
    .rom_if     (rom_if     ),
    .ctrl_if    (ctrl_if    )
  );

  // Interleaved L2 SRAM
  l2_mem i_l2_mem (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .bus  (l2_if)
  );

  bootrom i_bootrom (
    .clk_i(clk_i ),
    .rst_i(rst_i ),
    .bus  (rom_if)
  );

  // End of computation and wake-up towards the cores
  ctrl_registers i_ctrl_registers (
    .clk_i      (clk_i      ),
    .rst_i      (rst_i      ),
    .bus        (ctrl_if    ),
    .eoc_valid_o(eoc_valid_o),
    .wake_up_o  (wake_up_o  )
  );

endmodule : mempool_system

// ==== tb/system_tb.sv ====
// Testbench for the system memory side: host request driver,
// L2 byte and register reference model, response checking assertions

module system_tb;

  localparam int unsigned WaitLimit = 1000;
  localparam int unsigned L2Words   = system_pkg::L2Size / 4;

  logic                            clk_i       = 1'b0;
  logic                            rst_i       = 1'b1;
  logic                            req_valid_i = 1'b0;
  logic                            req_write_i = 1'b0;
  logic                            rsp_ready_i = 1'b1;
  system_pkg::addr_t               req_addr_i  = '0;
  system_pkg::data_t               req_wdata_i = '0;
  system_pkg::strb_t               req_strb_i  = '0;
  logic                            req_ready_o;
  logic                            rsp_valid_o;
  logic                            rsp_error_o;
  logic                            eoc_valid_o;
  system_pkg::data_t               rsp_rdata_o;
  logic [system_pkg::NumCores-1:0] wake_up_o;

  integer seed = 32'h3cd6f080;

  // Reference model state
  logic [7:0]                      l2_bytes [system_pkg::addr_t];
  logic [32:0]                     exp_q [$];
  logic [32:0]                     head_word  = '0;
  logic                            head_valid = 1'b0;
  system_pkg::data_t               eoc_model  = '0;
  logic [system_pkg::NumCores-1:0] wake_set   = '0;
  logic [system_pkg::NumCores-1:0] wake_exp   = '0;
  logic                            bp_on      = 1'b0;

  mempool_system dut0 (
    .clk_i      (clk_i      ),
    .rst_i      (rst_i      ),
    .req_valid_i(req_valid_i),
    .req_write_i(req_write_i),
    .rsp_ready_i(rsp_ready_i),
    .req_addr_i (req_addr_i ),
    .req_wdata_i(req_wdata_i),
    .req_strb_i (req_strb_i ),
    .req_ready_o(req_ready_o),
    .rsp_valid_o(rsp_valid_o),
    .rsp_error_o(rsp_error_o),
    .eoc_valid_o(eoc_valid_o),
    .rsp_rdata_o(rsp_rdata_o),
    .wake_up_o  (wake_up_o  )
  );

  always #2 clk_i = ~clk_i;

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_mismatch(input string msg);
    $display("FAILED at time %0t: %s", $time, msg);
    abort_run();
  endtask

  function automatic system_pkg::addr_t ctrl_addr(input system_pkg::ctrl_reg_e reg_sel);
    ctrl_addr = system_pkg::CtrlBaseAddr + (system_pkg::addr_t'(reg_sel) << 2);
  endfunction

  function automatic system_pkg::addr_t unmapped_addr(input int unsigned sel);
    case (sel % 4)
      0:       unmapped_addr = 32'h0000_0100;
      1:       unmapped_addr = system_pkg::L2BaseAddr + system_pkg::addr_t'(system_pkg::L2Size);
      2:       unmapped_addr = system_pkg::CtrlEndAddr;
      default: unmapped_addr = 32'hC000_0040;
    endcase
  endfunction

  // Applies an accepted request to the model and queues its response
  task automatic record_request(input system_pkg::addr_t addr, input logic write,
                                input system_pkg::data_t wdata, input system_pkg::strb_t strb);
    system_pkg::data_t rdata;
    system_pkg::addr_t idx;
    logic              err;
    rdata = '0;
    err   = 1'b0;
    if (addr >= system_pkg::L2BaseAddr &&
        addr < system_pkg::L2BaseAddr + system_pkg::addr_t'(system_pkg::L2Size)) begin
      for (int i = 0; i < 4; i++) begin
        idx = (addr & ~32'h3) + system_pkg::addr_t'(i);
        if (write && strb[i]) begin
          l2_bytes[idx] = wdata[8*i +: 8];
        end else if (!write) begin
          rdata[8*i +: 8] = l2_bytes[idx];
        end
      end
    end else if (addr >= system_pkg::BootromBaseAddr && addr < system_pkg::BootromEndAddr) begin
      idx = (addr - system_pkg::BootromBaseAddr) >> 2;
      if (write) begin
        err = 1'b1;
      end else if (idx < system_pkg::BootromNumWords) begin
        rdata = {system_pkg::BootromSignature, idx[15:0]};
      end
    end else if (addr >= system_pkg::CtrlBaseAddr && addr < system_pkg::CtrlEndAddr) begin
      idx = (addr - system_pkg::CtrlBaseAddr) >> 2;
      if (idx == system_pkg::addr_t'(system_pkg::RegEoc)) begin
        for (int i = 0; i < 4; i++) begin
          if (write && strb[i]) begin
            eoc_model[8*i +: 8] = wdata[8*i +: 8];
          end
        end
        rdata = write ? '0 : eoc_model;
      end else if (idx == system_pkg::addr_t'(system_pkg::RegWakeUp)) begin
        if (write) begin
          wake_set = wdata[system_pkg::NumCores-1:0];
        end
      end else if (idx == system_pkg::addr_t'(system_pkg::RegNumCores)) begin
        rdata = write ? '0 : system_pkg::data_t'(system_pkg::NumCores);
      end else begin
        err = 1'b1;
      end
    end else begin
      err = 1'b1;
    end
    exp_q.push_back({err, rdata});
  endtask

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic issue(input system_pkg::addr_t addr, input logic write,
                       input system_pkg::data_t wdata, input system_pkg::strb_t strb);
    int unsigned waited;
    logic        accepted;
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    req_write_i = write;
    req_wdata_i = wdata;
    req_strb_i  = strb;
    waited      = 0;
    accepted    = 1'b0;
    while (!accepted) begin
      @(posedge clk_i);
      if (req_ready_o) begin
        accepted = 1'b1;
      end else begin
        waited++;
        if (waited > WaitLimit) begin
          $display("request to address %h was never accepted", addr);
          abort_run();
        end
      end
    end
    record_request(addr, write, wdata, strb);
    @(negedge clk_i);
  endtask

  task automatic idle_cycles(input int unsigned n);
    req_valid_i = 1'b0;
    repeat (n) @(negedge clk_i);
  endtask

  // One request to a random target, with an occasional idle cycle
  task automatic random_op();
    integer            r;
    int unsigned       w;
    system_pkg::addr_t a;
    r = $random(seed);
    w = $unsigned($random(seed)) % L2Words;
    a = system_pkg::L2BaseAddr + system_pkg::addr_t'(4 * w);
    case ($unsigned(r) % 8)
      0, 1:    issue(a, 1'b1, $random(seed), $random(seed));
      2, 3:    issue(a, 1'b0, '0, '0);
      4:       issue(system_pkg::BootromBaseAddr + system_pkg::addr_t'(4 * (w % 80)), 1'b0, '0, '0);
      5:       issue(system_pkg::BootromBaseAddr + system_pkg::addr_t'(4 * w), 1'b1, w, 4'hF);
      6:       issue(unmapped_addr(w), r[0], w, 4'hF);
      default: issue(ctrl_addr(system_pkg::RegNumCores), 1'b0, '0, '0);
    endcase
    if ((($unsigned(r) >> 8) % 5) == 0) begin
      idle_cycles(1);
    end
  endtask

  task automatic wait_drained();
    int unsigned waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
      waited++;
      if (waited > WaitLimit) begin
        $display("%0d responses still outstanding after the wait limit", exp_q.size());
        abort_run();
      end
    end
  endtask

  // Random response back-pressure
  always @(negedge clk_i) begin
    rsp_ready_i = bp_on ? (($random(seed) & 3) != 0) : 1'b1;
  end

  // Expected head and wake-up pulse, stable through the next rising edge
  always @(negedge clk_i) begin
    head_valid = (exp_q.size() != 0);
    head_word  = head_valid ? exp_q[0] : '0;
    wake_exp   = wake_set;
    wake_set   = '0;
  end

  always @(posedge clk_i) begin
    if (!rst_i && rsp_valid_o && rsp_ready_i) begin
      if (exp_q.size() != 0) begin
        void'(exp_q.pop_front());
      end
    end
  end

  a_rsp_in_order : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (rsp_valid_o && rsp_ready_i) |->
      (head_valid && rsp_error_o == head_word[32] && rsp_rdata_o == head_word[31:0]))
    else report_mismatch($sformatf("response rdata %h error %b, expected rdata %h error %b",
      $sampled(rsp_rdata_o), $sampled(rsp_error_o),
      $sampled(head_word[31:0]), $sampled(head_word[32])));

  a_rsp_held : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (rsp_valid_o && !rsp_ready_i) |=>
      (rsp_valid_o && $stable(rsp_rdata_o) && $stable(rsp_error_o)))
    else report_mismatch("stalled response changed before its transfer");

  a_eoc_level : assert property (
    @(posedge clk_i) disable iff (rst_i) eoc_valid_o == eoc_model[0])
    else report_mismatch($sformatf("eoc_valid_o is %b, expected %b",
      $sampled(eoc_valid_o), $sampled(eoc_model[0])));

  a_wake_pulse : assert property (
    @(posedge clk_i) disable iff (rst_i) wake_up_o == wake_exp)
    else report_mismatch($sformatf("wake_up_o is %h, expected %h",
      $sampled(wake_up_o), $sampled(wake_exp)));

  initial begin
    int unsigned k;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    @(negedge clk_i);
    assert (!rsp_valid_o && !eoc_valid_o && wake_up_o == '0)
      else report_mismatch("outputs are not low after reset");

    // Known content in every L2 word before partial writes
    for (k = 0; k < L2Words; k++) begin
      issue(system_pkg::L2BaseAddr + system_pkg::addr_t'(4 * k), 1'b1, $random(seed), 4'hF);
    end

    bp_on = 1'b1;
    repeat (400) random_op();

    // Boot ROM walk past the populated words, then the window end and writes
    for (k = 0; k < system_pkg::BootromNumWords + 4; k++) begin
      issue(system_pkg::BootromBaseAddr + system_pkg::addr_t'(4 * k), 1'b0, '0, '0);
    end
    issue(system_pkg::BootromBaseAddr + 32'h0000_FFFC, 1'b0, '0, '0);
    issue(system_pkg::BootromBaseAddr + 32'h0000_0010, 1'b1, 32'hDEAD_BEEF, 4'hF);

    issue(ctrl_addr(system_pkg::RegEoc), 1'b1, 32'h0000_0001, 4'h1);
    issue(ctrl_addr(system_pkg::RegEoc), 1'b0, '0, '0);
    // Back to back wake-up writes give two separate pulses
    issue(ctrl_addr(system_pkg::RegWakeUp), 1'b1, 32'h0000_00A5, 4'hF);
    issue(ctrl_addr(system_pkg::RegWakeUp), 1'b1, 32'h0000_003C, 4'hF);
    issue(ctrl_addr(system_pkg::RegWakeUp), 1'b0, '0, '0);
    issue(ctrl_addr(system_pkg::RegNumCores), 1'b1, 32'hFFFF_FFFF, 4'hF);
    issue(ctrl_addr(system_pkg::RegNumCores), 1'b0, '0, '0);
    issue(system_pkg::CtrlBaseAddr + 32'h0000_0010, 1'b0, '0, '0);
    issue(unmapped_addr(0), 1'b0, '0, '0);
    issue(ctrl_addr(system_pkg::RegEoc), 1'b1, 32'h0000_0000, 4'hF);

    repeat (100) random_op();
    req_valid_i = 1'b0;
    wait_drained();
    bp_on = 1'b0;

    // A few quiet cycles so a duplicated response meets an empty queue
    idle_cycles(4);

    $display("NO ERRORS");
    $finish;
  end

endmodule : system_tb

// ==== sources.f ====
logic/system_pkg.sv
logic/mem_req_if.sv
logic/soc_demux.sv
logic/l2_mem.sv
logic/bootrom.sv
logic/ctrl_registers.sv
logic/mempool_system.sv
tb/system_tb.sv
